// File: source/decodePkg.sv
// decodePkg: instruction fields, opcodes, ALU and source enums, control word, stage payloads
package decodePkg;

    localparam int xlen = 32;

    localparam logic [31:0] nopInstr = 32'h0000_0013; // addi x0,x0,0

    // base opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    // R-type layout, the other formats reuse the same positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrFieldsT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        srcReg,   // rs1 / rs2
        srcImm,   // rs1 / imm
        srcPcImm  // pc / imm
    } aluSrcT;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memRead;
        logic   memWrite;
        aluOpT  aluOp;
        aluSrcT aluSrc;
        logic   jump;
        logic   branch;
    } controlT;

    typedef struct packed {
        logic [31:0]     instr;
        logic [xlen-1:0] pc;
    } fetchPacketT;

    typedef struct packed {
        controlT         ctrl;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [xlen-1:0] rData1;
        logic [xlen-1:0] rData2;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } decodedT;

    localparam decodedT bubbleDecoded = '0;

endpackage

// File: source/pipelineStage.sv
// pipelineStage: stage register with hold, bubble insert and a valid bit, any payload type
`timescale 1ns/10ps

module pipelineStage #(
    parameter type     payloadT = logic,
    parameter payloadT bubble   = '0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
            outData  <= bubble;
        end else if (flush) begin
            outValid <= 1'b0;   // bubble wins over hold
            outData  <= bubble;
        end else if (!stall) begin
            outValid <= inValid;
            outData  <= inData;
        end
    end

    // a flushed stage never presents a valid entry the cycle after
    flushClearsValid: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !outValid
    ) else $error("pipelineStage: valid entry after flush");

endmodule

// File: source/instructionDecoder.sv
// instructionDecoder: RV32I control word, register numbers, immediates and source usage
`timescale 1ns/10ps

module instructionDecoder (
    input  logic [31:0]        instr,
    output decodePkg::controlT ctrl,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd,
    output logic [2:0]         funct3,
    output logic [31:0]        imm,
    output logic               usesRs1,
    output logic               usesRs2
);
    import decodePkg::*;

    instrFieldsT fields;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // funct3 to ALU op, alt is funct7 bit 5
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt,
                                           input logic isReg);
        aluOpT op;
        case (f3)
            3'b000:  op = (isReg && alt) ? aluSub : aluAdd; // no subi
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    assign fields = instr;
    assign rs1    = fields.rs1;
    assign rs2    = fields.rs2;
    assign rd     = fields.rd;
    assign funct3 = fields.funct3;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl    = '0;   // unknown opcode stays a bubble
        imm     = '0;
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;
        case (fields.opcode)
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluPassB;
                ctrl.aluSrc   = srcImm;
                imm           = immU;
            end
            opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcPcImm;
                imm           = immU;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.aluSrc   = srcPcImm; // target pc+imm
                imm           = immJ;
            end
            opJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.aluSrc   = srcImm;
                imm           = immI;
                usesRs1       = 1'b1;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub; // compare
                imm         = immB;
                usesRs1     = 1'b1;
                usesRs2     = 1'b1;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = srcImm;
                imm           = immI;
                usesRs1       = 1'b1;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = srcImm;
                imm           = immS;
                usesRs1       = 1'b1;
                usesRs2       = 1'b1; // store data
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(fields.funct3, fields.funct7[5], 1'b0);
                ctrl.aluSrc   = srcImm;
                imm           = immI;
                usesRs1       = 1'b1;
            end
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(fields.funct3, fields.funct7[5], 1'b1);
                usesRs1       = 1'b1;
                usesRs2       = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: source/registerFile.sv
// registerFile: 32 entry integer registers, two read ports, write port with bypass
`timescale 1ns/10ps

module registerFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    output logic [decodePkg::xlen-1:0] rData1,
    output logic [decodePkg::xlen-1:0] rData2,
    input  logic                       wbEnable,
    input  logic [4:0]                 wbRd,
    input  logic [decodePkg::xlen-1:0] wbData
);
    import decodePkg::*;

    logic [xlen-1:0] regs [32];
    logic            wbLive;

    assign wbLive = wbEnable && (wbRd != 5'd0); // x0 never written

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbLive) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle write shows up on the read port
    assign rData1 = (rs1 == 5'd0) ? '0 :
                    (wbLive && wbRd == rs1) ? wbData : regs[rs1];
    assign rData2 = (rs2 == 5'd0) ? '0 :
                    (wbLive && wbRd == rs2) ? wbData : regs[rs2];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        (rs1 == 5'd0) |-> (rData1 == '0)
    ) else $error("registerFile: x0 read nonzero");

endmodule

// File: source/hazardUnit.sv
// hazardUnit: load-use detection, redirect and issue back-pressure to stage controls
`timescale 1ns/10ps

module hazardUnit (
    input  logic               redirect,
    input  logic               issueStall,
    input  logic               ifValid,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  logic               usesRs1,
    input  logic               usesRs2,
    input  logic               exValid,
    input  decodePkg::controlT exCtrl,
    input  logic [4:0]         exRd,
    output logic               ifStall,
    output logic               ifFlush,
    output logic               idStall,
    output logic               idFlush,
    output logic               fetchStall
);

    logic loadUse;

    // load in the issue register feeding the instruction now in decode
    assign loadUse = exValid && exCtrl.memRead && (exRd != 5'd0) && ifValid &&
                     ((usesRs1 && rs1 == exRd) || (usesRs2 && rs2 == exRd));

    always_comb begin
        ifStall    = 1'b0;
        ifFlush    = 1'b0;
        idStall    = 1'b0;
        idFlush    = 1'b0;
        fetchStall = 1'b0;
        if (redirect) begin
            ifFlush = 1'b1; // fetch input of this cycle dropped
            idFlush = 1'b1;
        end else if (issueStall) begin
            ifStall    = 1'b1;
            idStall    = 1'b1;
            fetchStall = 1'b1;
        end else if (loadUse) begin
            ifStall    = 1'b1;
            idFlush    = 1'b1; // bubble clears exValid, so one cycle only
            fetchStall = 1'b1;
        end
    end

    always_comb begin
        assert (!(redirect && fetchStall))
            else $error("hazardUnit: fetch held during redirect");
    end

endmodule

// File: source/decodeStage.sv
// decodeStage: fetch/decode and decode/issue registers around decoder, regfile and hazards
`timescale 1ns/10ps

module decodeStage #(
    parameter logic [decodePkg::xlen-1:0] resetPc = '0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetchValid,
    input  decodePkg::fetchPacketT     fetchData,
    input  logic                       redirect,
    input  logic                       issueStall,
    input  logic                       wbEnable,
    input  logic [4:0]                 wbRd,
    input  logic [decodePkg::xlen-1:0] wbData,
    output logic                       fetchStall,
    output logic                       issueValid,
    output decodePkg::decodedT         issueData
);
    import decodePkg::*;

    localparam fetchPacketT ifBubble = '{instr: nopInstr, pc: resetPc};

    logic            ifValid;
    fetchPacketT     ifData;
    controlT         decCtrl;
    logic [4:0]      decRs1;
    logic [4:0]      decRs2;
    logic [4:0]      decRd;
    logic [2:0]      decFunct3;
    logic [xlen-1:0] decImm;
    logic            usesRs1;
    logic            usesRs2;
    logic [xlen-1:0] rData1;
    logic [xlen-1:0] rData2;
    decodedT         idIn;
    logic            ifStall;
    logic            ifFlush;
    logic            idStall;
    logic            idFlush;

    pipelineStage #(
        .payloadT(fetchPacketT),
        .bubble  (ifBubble)
    ) ifStage (
        .clk     (clk),
        .reset   (reset),
        .stall   (ifStall),
        .flush   (ifFlush),
        .inValid (fetchValid),
        .inData  (fetchData),
        .outValid(ifValid),
        .outData (ifData)
    );

    instructionDecoder decoder (
        .instr  (ifData.instr),
        .ctrl   (decCtrl),
        .rs1    (decRs1),
        .rs2    (decRs2),
        .rd     (decRd),
        .funct3 (decFunct3),
        .imm    (decImm),
        .usesRs1(usesRs1),
        .usesRs2(usesRs2)
    );

    registerFile regFile (
        .clk     (clk),
        .reset   (reset),
        .rs1     (decRs1),
        .rs2     (decRs2),
        .rData1  (rData1),
        .rData2  (rData2),
        .wbEnable(wbEnable),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    // decoded fields plus operands into one issue word
    assign idIn = '{
        ctrl:   decCtrl,
        rs1:    decRs1,
        rs2:    decRs2,
        rd:     decRd,
        funct3: decFunct3,
        rData1: rData1,
        rData2: rData2,
        imm:    decImm,
        pc:     ifData.pc
    };

    pipelineStage #(
        .payloadT(decodedT),
        .bubble  (bubbleDecoded)
    ) idStage (
        .clk     (clk),
        .reset   (reset),
        .stall   (idStall),
        .flush   (idFlush),
        .inValid (ifValid),
        .inData  (idIn),
        .outValid(issueValid),
        .outData (issueData)
    );

    hazardUnit hazards (
        .redirect  (redirect),
        .issueStall(issueStall),
        .ifValid   (ifValid),
        .rs1       (decRs1),
        .rs2       (decRs2),
        .usesRs1   (usesRs1),
        .usesRs2   (usesRs2),
        .exValid   (issueValid),
        .exCtrl    (issueData.ctrl),
        .exRd      (issueData.rd),
        .ifStall   (ifStall),
        .ifFlush   (ifFlush),
        .idStall   (idStall),
        .idFlush   (idFlush),
        .fetchStall(fetchStall)
    );

endmodule

// File: test/decodeModel.svh
// decodeModel: reference decoder, LCG, instruction encoders and typed compare tasks
`ifndef decodeModelSvh
`define decodeModelSvh

function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// alt selects sub/sra
function automatic aluOpT expectedAlu(input logic [2:0] f3, input logic alt);
    aluOpT byFunct3 [8];
    byFunct3 = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
    if (alt && f3 == 3'b000) return aluSub;
    if (alt && f3 == 3'b101) return aluSra;
    return byFunct3[f3];
endfunction

// expected issue word, operands taken from the shadow registers
function automatic decodedT expectDecode(input logic [31:0] instr, input logic [31:0] at);
    decodedT    d;
    logic [6:0] op;
    logic [2:0] f3;
    op = instr[6:0];
    f3 = instr[14:12];
    d = '0;
    d.rs1 = instr[19:15];
    d.rs2 = instr[24:20];
    d.rd = instr[11:7];
    d.funct3 = f3;
    d.rData1 = shadow[instr[19:15]];
    d.rData2 = shadow[instr[24:20]];
    d.pc = at;
    d.ctrl.regWrite = op inside {opLui, opAuipc, opJal, opJalr, opLoad, opOpImm, opOp};
    d.ctrl.memRead = (op == opLoad);
    d.ctrl.memToReg = (op == opLoad);
    d.ctrl.memWrite = (op == opStore);
    d.ctrl.jump = op inside {opJal, opJalr};
    d.ctrl.branch = (op == opBranch);
    d.ctrl.aluSrc = (op inside {opAuipc, opJal}) ? srcPcImm :
                    (op inside {opLui, opJalr, opLoad, opStore, opOpImm}) ? srcImm : srcReg;
    case (op)
        opLui:    d.ctrl.aluOp = aluPassB;
        opBranch: d.ctrl.aluOp = aluSub;
        opOpImm:  d.ctrl.aluOp = expectedAlu(f3, instr[30] && f3 == 3'b101);
        opOp:     d.ctrl.aluOp = expectedAlu(f3, instr[30]);
        default:  d.ctrl.aluOp = aluAdd;
    endcase
    case (op)
        opLui, opAuipc:          d.imm = {instr[31:12], 12'h000};
        opJalr, opLoad, opOpImm: d.imm = 32'($signed(instr[31:20]));
        opStore:  d.imm = 32'($signed({instr[31:25], instr[11:7]}));
        opBranch: d.imm = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
        opJal:    d.imm = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
        default:  d.imm = '0;
    endcase
    return d;
endfunction

task automatic checkDecoded(input string name, input decodedT got, input decodedT exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        errorCount++;
        abortRun();
    end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        errorCount++;
        abortRun();
    end
endtask

task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        errorCount++;
        abortRun();
    end
endtask

`endif

// File: test/decodeStageTb.sv
// decodeStageTb: clock, reset, watchdog, directed decode stage tests and the UUT
`timescale 1ns/10ps

module decodeStageTb;
    import decodePkg::*;

    localparam int          randomCount    = 200;
    localparam int          watchdogCycles = 4 * randomCount + 1200;
    localparam logic [31:0] bootPc         = 32'h0000_1000;

    logic        clk = 1'b0;
    logic        reset;
    logic        fetchValid;
    fetchPacketT fetchData;
    logic        redirect;
    logic        issueStall;
    logic        wbEnable;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        fetchStall;
    logic        issueValid;
    decodedT     issueData;

    logic [31:0] shadow [32];   // expected register contents
    logic [31:0] lcgState;
    logic [31:0] fetchPc;
    int          errorCount;

    `include "decodeModel.svh"

    decodeStage #(.resetPc(bootPc)) UUT (.*);

    always #4 clk = ~clk;

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic driveFetch(input logic [31:0] instr);
        fetchValid = 1'b1;
        fetchData = '{instr: instr, pc: fetchPc};
        fetchPc = fetchPc + 32'd4;
    endtask

    task automatic stopFetch();
        fetchValid = 1'b0;
    endtask

    task automatic writeBack(input logic en, input logic [4:0] rd, input logic [31:0] data);
        wbEnable = en;
        wbRd = rd;
        wbData = data;
        if (en && rd != 5'd0) shadow[rd] = data;   // x0 stays zero
    endtask

    // one instruction through both registers, optional write-back in its decode cycle
    task automatic issueAndCheck(input logic [31:0] instr, input logic wbEn,
                                 input logic [4:0] rd, input logic [31:0] data);
        decodedT exp;
        driveFetch(instr);
        nextCycle();
        stopFetch();
        writeBack(wbEn, rd, data);
        exp = expectDecode(instr, fetchData.pc);
        checkBit("issueValid", issueValid, 1'b0);
        nextCycle();
        writeBack(1'b0, 5'd0, 32'd0);
        checkBit("issueValid", issueValid, 1'b1);
        checkDecoded("issueData", issueData, exp);
    endtask

    task automatic testFormats();
        logic [31:0] prog [10];
        prog = '{
            encU(20'h12345, 5'd3, opLui),
            encU(20'hfffff, 5'd4, opAuipc),
            encJ(21'h1ffff8, 5'd1),                       // jal x1,-8
            encI(12'h010, 5'd1, 3'b000, 5'd2, opJalr),
            encB(13'h1ff0, 5'd2, 5'd1, 3'b000),           // beq x1,x2,-16
            encI(12'hffc, 5'd2, 3'b010, 5'd5, opLoad),    // lw x5,-4(x2)
            encS(12'h024, 5'd6, 5'd2, 3'b010),
            encI(12'h7ff, 5'd3, 3'b000, 5'd7, opOpImm),
            encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd8),   // sub
            encR(7'b0100000, 5'd4, 5'd3, 3'b101, 5'd9)    // sra
        };
        foreach (prog[i]) issueAndCheck(prog[i], 1'b0, 5'd0, 32'd0);
    endtask

    task automatic testRegisterFile();
        for (int r = 1; r < 8; r++) begin
            writeBack(1'b1, 5'(r), lcgNext());
            nextCycle();
        end
        writeBack(1'b1, 5'd0, 32'hdead_beef);
        nextCycle();
        writeBack(1'b0, 5'd0, 32'd0);
        issueAndCheck(encR(7'd0, 5'd2, 5'd1, 3'b000, 5'd8), 1'b0, 5'd0, 32'd0);
        issueAndCheck(encR(7'd0, 5'd3, 5'd0, 3'b000, 5'd9), 1'b0, 5'd0, 32'd0);
        checkWord("rData1 from x0", issueData.rData1, 32'd0);
        issueAndCheck(encR(7'd0, 5'd5, 5'd4, 3'b110, 5'd10), 1'b1, 5'd4, 32'h1357_9bdf);
        checkWord("rData1 bypassed", issueData.rData1, 32'h1357_9bdf);
        issueAndCheck(encR(7'd0, 5'd5, 5'd4, 3'b111, 5'd11), 1'b0, 5'd0, 32'd0);
        checkWord("rData1 committed", issueData.rData1, 32'h1357_9bdf);
    endtask

    task automatic testLoadUse(input logic [31:0] user, input logic hazard);
        decodedT expLoad;
        decodedT expUser;
        driveFetch(encI(12'd0, 5'd2, 3'b010, 5'd5, opLoad));   // lw x5,0(x2)
        nextCycle();
        expLoad = expectDecode(fetchData.instr, fetchData.pc);
        driveFetch(user);
        nextCycle();
        stopFetch();
        expUser = expectDecode(user, fetchData.pc);
        checkBit("issueValid load", issueValid, 1'b1);
        checkDecoded("issueData load", issueData, expLoad);
        checkBit("fetchStall", fetchStall, hazard);
        if (hazard) begin
            nextCycle();
            checkBit("issueValid bubble", issueValid, 1'b0);
            checkBit("fetchStall released", fetchStall, 1'b0);
        end
        nextCycle();
        checkBit("issueValid", issueValid, 1'b1);
        checkDecoded("issueData user", issueData, expUser);
        nextCycle();
    endtask

    task automatic testRedirect();
        decodedT expNext;
        driveFetch(encI(12'd1, 5'd1, 3'b000, 5'd11, opOpImm));
        nextCycle();
        driveFetch(encI(12'd2, 5'd1, 3'b000, 5'd12, opOpImm));
        nextCycle();
        driveFetch(encI(12'd3, 5'd1, 3'b000, 5'd13, opOpImm));   // dropped by redirect
        redirect = 1'b1;
        #1;
        checkBit("fetchStall in redirect", fetchStall, 1'b0);
        nextCycle();
        redirect = 1'b0;
        driveFetch(encI(12'd4, 5'd1, 3'b000, 5'd14, opOpImm));
        checkBit("issueValid bubble 1", issueValid, 1'b0);
        checkDecoded("issueData bubble 1", issueData, '0);
        nextCycle();
        stopFetch();
        expNext = expectDecode(fetchData.instr, fetchData.pc);
        checkBit("issueValid bubble 2", issueValid, 1'b0);
        // nop at the reset pc, left by the flushed fetch/decode register
        checkDecoded("issueData bubble 2", issueData, expectDecode(nopInstr, bootPc));
        nextCycle();
        checkBit("issueValid", issueValid, 1'b1);
        checkDecoded("issueData after redirect", issueData, expNext);
    endtask

    task automatic testBackPressure();
        decodedT expA;
        decodedT expB;
        decodedT expC;
        driveFetch(encR(7'd0, 5'd2, 5'd1, 3'b100, 5'd15));
        nextCycle();
        expA = expectDecode(fetchData.instr, fetchData.pc);
        driveFetch(encR(7'd0, 5'd3, 5'd2, 3'b001, 5'd16));
        nextCycle();
        expB = expectDecode(fetchData.instr, fetchData.pc);
        driveFetch(encR(7'd0, 5'd4, 5'd3, 3'b011, 5'd17));   // held by fetch
        issueStall = 1'b1;
        repeat (3) begin
            #1;
            checkBit("fetchStall held", fetchStall, 1'b1);
            checkBit("issueValid held", issueValid, 1'b1);
            checkDecoded("issueData held", issueData, expA);
            nextCycle();
        end
        issueStall = 1'b0;
        #1;
        checkBit("fetchStall released", fetchStall, 1'b0);
        checkDecoded("issueData before release", issueData, expA);
        nextCycle();
        stopFetch();
        expC = expectDecode(fetchData.instr, fetchData.pc);
        checkDecoded("issueData second", issueData, expB);
        nextCycle();
        checkDecoded("issueData third", issueData, expC);
        nextCycle();
        checkBit("issueValid drained", issueValid, 1'b0);
    endtask

    task automatic testRandomStream();
        decodedT     expQ [$];
        logic [31:0] r;
        logic [31:0] word;
        logic        inIf;
        int          sent;
        int          issued;
        inIf = 1'b0;
        sent = 0;
        issued = 0;
        while (issued < randomCount) begin
            if (issueValid) begin
                if (expQ.size() == 0) begin
                    $display("issueValid high at %0t with nothing in flight", $time);
                    abortRun();
                end
                checkDecoded("issueData random", issueData, expQ.pop_front());
                issued++;
            end
            r = lcgNext();
            writeBack(r[31], r[30:26], lcgNext());
            if (inIf) expQ.push_back(expectDecode(fetchData.instr, fetchData.pc));
            if (sent < randomCount) begin
                word = lcgNext();
                if (word[6])
                    word = encR({1'b0, word[30], 5'd0}, word[24:20], word[19:15],
                                word[14:12], word[11:7]);
                else
                    word = encI(word[31:20], word[19:15], word[14:12], word[11:7], opOpImm);
                driveFetch(word);
                sent++;
            end else begin
                stopFetch();
            end
            inIf = fetchValid;
            nextCycle();
        end
        writeBack(1'b0, 5'd0, 32'd0);
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout after %0d cycles, a test never completed", watchdogCycles);
        abortRun();
    end

    initial begin
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchData = '{instr: nopInstr, pc: '0};
        redirect = 1'b0;
        issueStall = 1'b0;
        wbEnable = 1'b0;
        wbRd = 5'd0;
        wbData = 32'd0;
        lcgState = 32'd16;
        fetchPc = bootPc;
        errorCount = 0;
        foreach (shadow[i]) shadow[i] = 32'd0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        checkBit("issueValid after reset", issueValid, 1'b0);
        checkBit("fetchStall after reset", fetchStall, 1'b0);
        checkDecoded("issueData after reset", issueData, '0);
        testFormats();
        testRegisterFile();
        testLoadUse(encR(7'd0, 5'd1, 5'd5, 3'b000, 5'd6), 1'b1);   // add x6,x5,x1
        testLoadUse(encR(7'd0, 5'd1, 5'd7, 3'b000, 5'd6), 1'b0);   // add x6,x7,x1
        testRedirect();
        testBackPressure();
        testRandomStream();
        if (errorCount == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("%0d checks failed", errorCount);
            abortRun();
        end
    end

endmodule

// File: flist.f
+incdir+test
source/decodePkg.sv
source/pipelineStage.sv
source/instructionDecoder.sv
source/registerFile.sv
source/hazardUnit.sv
source/decodeStage.sv
test/decodeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module decodeStageTb \
    -Mdir obj_dir -o decodeStageSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/decodeStageSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
echo "simulation passed"
exit 0
